// ==== src/jtag_pkg.sv ====
// JTAG TAP protocol constants for the debug transport module
// instruction codes, the IDCODE value, DTMCONTROL fields and TAP states
// items are referenced by scoped names from the TAP logic

package jtag_pkg;

    localparam int IRLEN = 5;
    localparam logic [31:0] IDCODE = 32'h10e31913;

    localparam logic [IRLEN-1:0] IR_IDCODE     = 5'h01;
    localparam logic [IRLEN-1:0] IR_DTMCONTROL = 5'h10;
    localparam logic [IRLEN-1:0] IR_DBUS       = 5'h11;
    localparam logic [IRLEN-1:0] IR_BYPASS     = 5'h1f;

    localparam logic [3:0] DTM_VERSION = 4'h1; // debug spec 0.13
    localparam int DTMCONTROL_DMIRESET     = 16;
    localparam int DTMCONTROL_DMIHARDRESET = 17;

    // IEEE 1149.1 controller states
    typedef enum logic [3:0] {
        RESET_TAP      = 4'h0,
        IDLE           = 4'h1,
        SELECT_DR_SCAN = 4'h2,
        CAPTURE_DR     = 4'h3,
        SHIFT_DR       = 4'h4,
        EXIT1_DR       = 4'h5,
        PAUSE_DR       = 4'h6,
        EXIT2_DR       = 4'h7,
        UPDATE_DR      = 4'h8,
        SELECT_IR_SCAN = 4'h9,
        CAPTURE_IR     = 4'ha,
        SHIFT_IR       = 4'hb,
        EXIT1_IR       = 4'hc,
        PAUSE_IR       = 4'hd,
        EXIT2_IR       = 4'he,
        UPDATE_IR      = 4'hf
    } tap_state_e;

endpackage

// ==== src/dmi_pkg.sv ====
// debug module interface definitions
// bus field widths, status codes and the data register map,
// shared by the TAP, the arbiter, the register bank and the bench model

package dmi_pkg;

    localparam int DMI_ABITS = 7;

    typedef logic [DMI_ABITS-1:0] dmi_addr_t;
    typedef logic [31:0]          dmi_data_t;
    typedef logic [1:0]           dmi_stat_t;

    // op/status field as seen in a DBUS capture
    localparam dmi_stat_t DMISTAT_SUCCESS = 2'h0;
    localparam dmi_stat_t DMISTAT_FAILED  = 2'h2;
    localparam dmi_stat_t DMISTAT_BUSY    = 2'h3;

    // DBUS scan is {addr, data, op}
    localparam int DBUS_LEN = DMI_ABITS + $bits(dmi_data_t) + $bits(dmi_stat_t);

    // data registers live at DATA_REG_BASE .. DATA_REG_BASE + DATA_REG_COUNT - 1
    localparam int DATA_REG_COUNT = 16;
    localparam int DATA_IDX_BITS  = $clog2(DATA_REG_COUNT);
    localparam int DATA_REG_BASE  = 0;

endpackage

// ==== src/dmi_if.sv ====
// one DMI request/response path
// the requester drives a single-cycle strobe with its command fields,
// the target answers with read data and the busy and error levels

`timescale 1ns/1ps

interface dmi_if;

    logic               req_valid;  // one-cycle strobe
    logic               req_write;
    dmi_pkg::dmi_addr_t req_addr;
    dmi_pkg::dmi_data_t req_wdata;

    dmi_pkg::dmi_data_t resp_rdata; // holds until the next read
    logic               busy;
    logic               error;      // sticky in the target

    modport requester (
        output req_valid, req_write, req_addr, req_wdata,
        input  resp_rdata, busy, error
    );

    modport target (
        input  req_valid, req_write, req_addr, req_wdata,
        output resp_rdata, busy, error
    );

endinterface

// ==== src/jtag_dtm.sv ====
// JTAG debug transport module
// full 16-state TAP controller with IDCODE, DTMCONTROL, DBUS and BYPASS,
// DBUS updates become single-cycle DMI strobes, DTMCONTROL updates pulse
// the DMI reset outputs. IR is loaded on the falling edge of TCK

`timescale 1ns/1ps

module jtag_dtm (
    input  logic     i_tck,
    input  logic     i_trst,
    input  logic     i_tms,
    input  logic     i_tdi,
    output logic     o_tdo,
    dmi_if.requester o_dmi,
    output logic     o_dmi_reset,
    output logic     o_dmi_hardreset
);

    jtag_pkg::tap_state_e          state;
    jtag_pkg::tap_state_e          state_nxt;
    logic [dmi_pkg::DBUS_LEN-1:0]  dr;
    logic [dmi_pkg::DBUS_LEN-1:0]  dr_nxt;
    logic [5:0]                    dr_len;     // active DR length
    logic [5:0]                    dr_len_nxt;
    logic                          bypass_q;
    logic                          bypass_nxt;
    logic [jtag_pkg::IRLEN-1:0]    ir;
    dmi_pkg::dmi_addr_t            dmi_addr_q; // echoed in the next DBUS capture
    dmi_pkg::dmi_stat_t            stat;
    logic                          upd_dbus;
    logic                          upd_ctrl;

    // TAP controller
    always_comb begin
        case (state)
            jtag_pkg::RESET_TAP:      state_nxt = i_tms ? jtag_pkg::RESET_TAP : jtag_pkg::IDLE;
            jtag_pkg::IDLE:           state_nxt = i_tms ? jtag_pkg::SELECT_DR_SCAN : jtag_pkg::IDLE;
            jtag_pkg::SELECT_DR_SCAN: state_nxt = i_tms ? jtag_pkg::SELECT_IR_SCAN
                                                        : jtag_pkg::CAPTURE_DR;
            jtag_pkg::CAPTURE_DR:     state_nxt = i_tms ? jtag_pkg::EXIT1_DR : jtag_pkg::SHIFT_DR;
            jtag_pkg::SHIFT_DR:       state_nxt = i_tms ? jtag_pkg::EXIT1_DR : jtag_pkg::SHIFT_DR;
            jtag_pkg::EXIT1_DR:       state_nxt = i_tms ? jtag_pkg::UPDATE_DR : jtag_pkg::PAUSE_DR;
            jtag_pkg::PAUSE_DR:       state_nxt = i_tms ? jtag_pkg::EXIT2_DR : jtag_pkg::PAUSE_DR;
            jtag_pkg::EXIT2_DR:       state_nxt = i_tms ? jtag_pkg::UPDATE_DR : jtag_pkg::SHIFT_DR;
            jtag_pkg::UPDATE_DR:      state_nxt = i_tms ? jtag_pkg::SELECT_DR_SCAN : jtag_pkg::IDLE;
            jtag_pkg::SELECT_IR_SCAN: state_nxt = i_tms ? jtag_pkg::RESET_TAP : jtag_pkg::CAPTURE_IR;
            jtag_pkg::CAPTURE_IR:     state_nxt = i_tms ? jtag_pkg::EXIT1_IR : jtag_pkg::SHIFT_IR;
            jtag_pkg::SHIFT_IR:       state_nxt = i_tms ? jtag_pkg::EXIT1_IR : jtag_pkg::SHIFT_IR;
            jtag_pkg::EXIT1_IR:       state_nxt = i_tms ? jtag_pkg::UPDATE_IR : jtag_pkg::PAUSE_IR;
            jtag_pkg::PAUSE_IR:       state_nxt = i_tms ? jtag_pkg::EXIT2_IR : jtag_pkg::PAUSE_IR;
            jtag_pkg::EXIT2_IR:       state_nxt = i_tms ? jtag_pkg::UPDATE_IR : jtag_pkg::SHIFT_IR;
            default:                  state_nxt = i_tms ? jtag_pkg::SELECT_DR_SCAN : jtag_pkg::IDLE;
        endcase
    end

    // busy wins over a sticky error
    always_comb begin
        if (o_dmi.busy)
            stat = dmi_pkg::DMISTAT_BUSY;
        else if (o_dmi.error)
            stat = dmi_pkg::DMISTAT_FAILED;
        else
            stat = dmi_pkg::DMISTAT_SUCCESS;
    end

    // shift register path, IR scans reuse the low bits of dr
    always_comb begin
        dr_nxt     = dr;
        dr_len_nxt = dr_len;
        bypass_nxt = bypass_q;
        case (state)
            jtag_pkg::CAPTURE_DR: begin
                case (ir)
                    jtag_pkg::IR_IDCODE: begin
                        dr_nxt     = {{(dmi_pkg::DBUS_LEN-32){1'b0}}, jtag_pkg::IDCODE};
                        dr_len_nxt = 6'd32;
                    end
                    jtag_pkg::IR_DTMCONTROL: begin
                        dr_nxt        = '0;
                        dr_nxt[3:0]   = jtag_pkg::DTM_VERSION;
                        dr_nxt[9:4]   = 6'(dmi_pkg::DMI_ABITS);  // abits field
                        dr_nxt[11:10] = stat;                     // dmistat
                        dr_len_nxt    = 6'd32;
                    end
                    jtag_pkg::IR_DBUS: begin
                        dr_nxt     = {dmi_addr_q, o_dmi.resp_rdata, stat};
                        dr_len_nxt = 6'(dmi_pkg::DBUS_LEN);
                    end
                    default: begin // BYPASS and any unknown code
                        dr_nxt[0]  = bypass_q;
                        dr_len_nxt = 6'd1;
                    end
                endcase
            end
            jtag_pkg::SHIFT_DR: begin
                dr_nxt = dr >> 1;
                dr_nxt[dr_len - 6'd1] = i_tdi; // tdi enters at the top of the active length
            end
            jtag_pkg::UPDATE_DR: begin
                if (ir == jtag_pkg::IR_BYPASS)
                    bypass_nxt = dr[0];
            end
            jtag_pkg::CAPTURE_IR: begin
                dr_nxt[jtag_pkg::IRLEN-1:0] = {ir[jtag_pkg::IRLEN-1:2], 2'b01};
            end
            jtag_pkg::SHIFT_IR: begin
                dr_nxt[jtag_pkg::IRLEN-1:0] = {i_tdi, dr[jtag_pkg::IRLEN-1:1]};
            end
            default: begin
            end
        endcase
    end

    assign upd_dbus = (state == jtag_pkg::UPDATE_DR) && (ir == jtag_pkg::IR_DBUS);
    assign upd_ctrl = (state == jtag_pkg::UPDATE_DR) && (ir == jtag_pkg::IR_DTMCONTROL);

    // op 1 reads, op 2 writes
    assign o_dmi.req_valid = upd_dbus && (dr[1:0] != 2'b00);
    assign o_dmi.req_write = dr[1];
    assign o_dmi.req_wdata = dr[2 +: 32];
    assign o_dmi.req_addr  = dr[dmi_pkg::DBUS_LEN-1 -: dmi_pkg::DMI_ABITS];

    assign o_dmi_reset     = upd_ctrl && dr[jtag_pkg::DTMCONTROL_DMIRESET];
    assign o_dmi_hardreset = upd_ctrl && dr[jtag_pkg::DTMCONTROL_DMIHARDRESET];

    assign o_tdo = dr[0];

    always_ff @(posedge i_tck or posedge i_trst) begin
        if (i_trst) begin
            state      <= jtag_pkg::RESET_TAP;
            dr         <= {{(dmi_pkg::DBUS_LEN-32){1'b0}}, jtag_pkg::IDCODE};
            dr_len     <= 6'd32;
            bypass_q   <= 1'b0;
            dmi_addr_q <= '0;
        end else begin
            state    <= state_nxt;
            dr       <= dr_nxt;
            dr_len   <= dr_len_nxt;
            bypass_q <= bypass_nxt;
            if (o_dmi.req_valid)
                dmi_addr_q <= o_dmi.req_addr;
        end
    end

    // instruction register on the falling edge
    always_ff @(negedge i_tck or posedge i_trst) begin
        if (i_trst)
            ir <= jtag_pkg::IR_IDCODE;
        else if (state == jtag_pkg::RESET_TAP)
            ir <= jtag_pkg::IR_IDCODE;
        else if (state == jtag_pkg::UPDATE_IR)
            ir <= dr[jtag_pkg::IRLEN-1:0];
    end

    // a DMI strobe only comes in the cycle after a DR shift is closed
    a_strobe_in_update: assert property (@(posedge i_tck) disable iff (i_trst)
        o_dmi.req_valid |-> ($past(state) == jtag_pkg::EXIT1_DR) ||
                            ($past(state) == jtag_pkg::EXIT2_DR));

    a_state_known: assert property (@(posedge i_tck) disable iff (i_trst)
        !$isunknown(state));

endmodule

// ==== src/dmi_arbiter.sv ====
// fixed-priority DMI arbiter between the TAP and the host port
// the TAP wins a same-cycle contest; a losing or early host request waits
// in a single pending slot. Granted requests go out one cycle later

`timescale 1ns/1ps

module dmi_arbiter (
    input  logic               i_tck,
    input  logic               i_trst,
    dmi_if.target              i_dtm,
    dmi_if.requester           o_dm,
    input  logic               i_host_req,
    input  logic               i_host_write,
    input  dmi_pkg::dmi_addr_t i_host_addr,
    input  dmi_pkg::dmi_data_t i_host_wdata,
    output dmi_pkg::dmi_data_t o_host_rdata,
    output logic               o_host_busy
);

    logic               own_dtm_q;  // owner of the in-flight access
    logic               own_host_q;
    logic               issue_q;
    logic               done;
    logic               bus_free;
    logic               dtm_acc;
    logic               grant_host;
    logic               pend_load;
    logic               pend_q;
    logic               pend_write_q;
    dmi_pkg::dmi_addr_t pend_addr_q;
    dmi_pkg::dmi_data_t pend_wdata_q;
    logic               write_q;
    dmi_pkg::dmi_addr_t addr_q;
    dmi_pkg::dmi_data_t wdata_q;
    logic               cap_dtm_q;  // target rdata valid for this owner now
    logic               cap_host_q;
    dmi_pkg::dmi_data_t dtm_rdata_q;
    dmi_pkg::dmi_data_t host_rdata_q;

    assign done     = (own_dtm_q || own_host_q) && !o_dm.busy;
    assign bus_free = !(own_dtm_q || own_host_q) || done;

    assign i_dtm.busy = own_dtm_q || !bus_free;
    assign dtm_acc    = i_dtm.req_valid && !i_dtm.busy; // strobes while busy are dropped
    assign grant_host = bus_free && !dtm_acc && (pend_q || i_host_req);
    assign pend_load  = i_host_req && !pend_q && !grant_host;

    always_ff @(posedge i_tck or posedge i_trst) begin
        if (i_trst) begin
            issue_q    <= 1'b0;
            own_dtm_q  <= 1'b0;
            own_host_q <= 1'b0;
            pend_q     <= 1'b0;
            cap_dtm_q  <= 1'b0;
            cap_host_q <= 1'b0;
        end else begin
            issue_q <= dtm_acc || grant_host;
            if (dtm_acc || grant_host) begin
                own_dtm_q  <= dtm_acc;
                own_host_q <= grant_host;
            end else if (done) begin
                own_dtm_q  <= 1'b0;
                own_host_q <= 1'b0;
            end
            cap_dtm_q  <= done && own_dtm_q && !write_q;
            cap_host_q <= done && own_host_q && !write_q;
            if (pend_load)
                pend_q <= 1'b1;
            else if (grant_host)
                pend_q <= 1'b0;
        end
    end

    always_ff @(posedge i_tck) begin
        if (dtm_acc) begin
            write_q <= i_dtm.req_write;
            addr_q  <= i_dtm.req_addr;
            wdata_q <= i_dtm.req_wdata;
        end else if (grant_host) begin
            write_q <= pend_q ? pend_write_q : i_host_write;
            addr_q  <= pend_q ? pend_addr_q : i_host_addr;
            wdata_q <= pend_q ? pend_wdata_q : i_host_wdata;
        end
        if (pend_load) begin
            pend_write_q <= i_host_write;
            pend_addr_q  <= i_host_addr;
            pend_wdata_q <= i_host_wdata;
        end
        if (cap_dtm_q)
            dtm_rdata_q <= o_dm.resp_rdata;
        if (cap_host_q)
            host_rdata_q <= o_dm.resp_rdata;
    end

    assign o_dm.req_valid = issue_q;
    assign o_dm.req_write = write_q;
    assign o_dm.req_addr  = addr_q;
    assign o_dm.req_wdata = wdata_q;

    // pass fresh read data through in its first cycle
    assign i_dtm.resp_rdata = cap_dtm_q ? o_dm.resp_rdata : dtm_rdata_q;
    assign i_dtm.error      = o_dm.error;
    assign o_host_rdata     = cap_host_q ? o_dm.resp_rdata : host_rdata_q;
    assign o_host_busy      = pend_q || own_host_q;

    a_no_strobe_on_busy: assert property (@(posedge i_tck) disable iff (i_trst)
        o_dm.req_valid && o_dm.busy |=> !o_dm.req_valid);

    // every issued access has exactly one owner
    a_owner_onehot: assert property (@(posedge i_tck) disable iff (i_trst)
        $onehot0({own_dtm_q, own_host_q}) &&
        (!o_dm.req_valid || $onehot({own_dtm_q, own_host_q})));

endmodule

// ==== src/dm_data_regs.sv ====
// debug data register bank behind the DMI
// sixteen 32-bit words answering in one cycle; unmapped accesses set a
// sticky error. dmireset clears the error, dmihardreset clears everything

`timescale 1ns/1ps

module dm_data_regs (
    input  logic  i_tck,
    input  logic  i_trst,
    dmi_if.target i_bus,
    input  logic  i_dmi_reset,
    input  logic  i_dmi_hardreset
);

    dmi_pkg::dmi_data_t                regs [dmi_pkg::DATA_REG_COUNT];
    dmi_pkg::dmi_addr_t                idx;  // offset from the base
    logic [dmi_pkg::DATA_IDX_BITS-1:0] sel;
    logic                              hit;
    logic                              error_q;
    dmi_pkg::dmi_data_t                rdata_q;

    assign idx = i_bus.req_addr - dmi_pkg::dmi_addr_t'(dmi_pkg::DATA_REG_BASE);
    assign hit = idx < dmi_pkg::dmi_addr_t'(dmi_pkg::DATA_REG_COUNT);
    assign sel = idx[dmi_pkg::DATA_IDX_BITS-1:0];

    always_ff @(posedge i_tck or posedge i_trst) begin
        if (i_trst) begin
            for (int i = 0; i < dmi_pkg::DATA_REG_COUNT; i++)
                regs[i] <= '0;
        end else if (i_dmi_hardreset) begin
            for (int i = 0; i < dmi_pkg::DATA_REG_COUNT; i++)
                regs[i] <= '0;
        end else if (i_bus.req_valid && i_bus.req_write && hit) begin
            regs[sel] <= i_bus.req_wdata;
        end
    end

    // sticky until a dmireset or hardreset
    always_ff @(posedge i_tck or posedge i_trst) begin
        if (i_trst)
            error_q <= 1'b0;
        else if (i_dmi_reset || i_dmi_hardreset)
            error_q <= 1'b0;
        else if (i_bus.req_valid && !hit)
            error_q <= 1'b1;
    end

    always_ff @(posedge i_tck) begin
        if (i_bus.req_valid && !i_bus.req_write)
            rdata_q <= hit ? regs[sel] : '0; // unmapped reads return zero
    end

    assign i_bus.resp_rdata = rdata_q;
    assign i_bus.busy       = 1'b0;   // single-cycle target
    assign i_bus.error      = error_q;

    a_valid_known: assert property (@(posedge i_tck) disable iff (i_trst)
        !$isunknown(i_bus.req_valid));

endmodule

// ==== src/dbg_top.sv ====
// debug transport subsystem top level
// JTAG pins and a system-side host port share one DMI bus into the data
// register bank; the TAP has priority on that bus

`timescale 1ns/1ps

module dbg_top (
    input  logic               i_tck,
    input  logic               i_trst,
    input  logic               i_tms,
    input  logic               i_tdi,
    output logic               o_tdo,
    input  logic               i_host_req,
    input  logic               i_host_write,
    input  dmi_pkg::dmi_addr_t i_host_addr,
    input  dmi_pkg::dmi_data_t i_host_wdata,
    output dmi_pkg::dmi_data_t o_host_rdata,
    output logic               o_host_busy
);

    dmi_if dtm_bus ();  // TAP to arbiter
    dmi_if dm_bus ();   // arbiter to register bank

    logic dmi_reset;
    logic dmi_hardreset;

    jtag_dtm u_dtm (
        .i_tck           (i_tck),
        .i_trst          (i_trst),
        .i_tms           (i_tms),
        .i_tdi           (i_tdi),
        .o_tdo           (o_tdo),
        .o_dmi           (dtm_bus.requester),
        .o_dmi_reset     (dmi_reset),
        .o_dmi_hardreset (dmi_hardreset)
    );

    dmi_arbiter u_arb (
        .i_tck        (i_tck),
        .i_trst       (i_trst),
        .i_dtm        (dtm_bus.target),
        .o_dm         (dm_bus.requester),
        .i_host_req   (i_host_req),
        .i_host_write (i_host_write),
        .i_host_addr  (i_host_addr),
        .i_host_wdata (i_host_wdata),
        .o_host_rdata (o_host_rdata),
        .o_host_busy  (o_host_busy)
    );

    dm_data_regs u_regs (
        .i_tck           (i_tck),
        .i_trst          (i_trst),
        .i_bus           (dm_bus.target),
        .i_dmi_reset     (dmi_reset),
        .i_dmi_hardreset (dmi_hardreset)
    );

endmodule

// ==== bench/tb_checker.sv ====
// result checker for the debug transport testbench
// the test sequence hands it named expected/actual pairs; it also watches
// the host port and expects o_host_busy in the cycle after each host strobe

`timescale 1ns/1ps

module tb_checker (
    input  logic i_tck,
    input  logic i_trst,
    input  logic i_host_req,
    input  logic i_host_busy,
    output int   o_errors
);

    int   checks = 0;
    int   passes = 0;
    int   errors = 0;
    logic strobe_seen = 1'b0;  // host strobe in the previous cycle

    assign o_errors = errors;

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Mismatch %s: expected %0h, actual %0h", name, expected, actual);
        end else begin
            passes++;
            $display("ok %s: %0h", name, actual);
        end
    endtask

    task automatic report_error(input string what);
        checks++;
        errors++;
        $display("Error: %s", what);
    endtask

    task automatic print_counts();
        $display("checks %0d, passed %0d, failed %0d", checks, passes, errors);
    endtask

    // mid-cycle sample, host pins are settled by the falling edge
    always @(negedge i_tck) begin
        if (i_trst) begin
            strobe_seen <= 1'b0;
        end else begin
            if (strobe_seen && !i_host_busy)
                report_error("o_host_busy stayed low in the cycle after a host strobe");
            strobe_seen <= i_host_req;
        end
    end

endmodule

// ==== bench/tb_top.sv ====
// testbench top for the debug transport subsystem
// drives JTAG scans and host port accesses with seeded random data and
// predicts each result from a word array model; tb_checker compares

`timescale 1ns/1ps

module tb_top;

    localparam int POLL_MAX  = 8;
    localparam int WAIT_MAX  = 16;
    localparam int UPD_CYCLE = 3 + dmi_pkg::DBUS_LEN + 1; // UPDATE_DR cycle of a DBUS scan

    logic               i_tck = 1'b0;
    logic               i_trst;
    logic               i_tms;
    logic               i_tdi;
    logic               o_tdo;
    logic               i_host_req;
    logic               i_host_write;
    dmi_pkg::dmi_addr_t i_host_addr;
    dmi_pkg::dmi_data_t i_host_wdata;
    dmi_pkg::dmi_data_t o_host_rdata;
    logic               o_host_busy;
    int                 errors;
    dmi_pkg::dmi_data_t model [16];
    logic               model_err;
    logic               bypass_bit;  // last bit left in the bypass register

    always #20 i_tck = ~i_tck;

    dbg_top DUT (.*);

    tb_checker u_check (
        .i_tck       (i_tck),
        .i_trst      (i_trst),
        .i_host_req  (i_host_req),
        .i_host_busy (o_host_busy),
        .o_errors    (errors)
    );

    task automatic tick();
        @(posedge i_tck);
        #2;
    endtask

    task automatic step(input logic tms, input logic tdi);
        i_tms = tms;
        i_tdi = tdi;
        tick();
    endtask

    task automatic tap_reset();
        repeat (5) step(1'b1, 1'b0);
        step(1'b0, 1'b0);  // park in IDLE
    endtask

    // one DR or IR scan from IDLE back to IDLE, lsb first
    task automatic scan(input logic is_ir, input int len, input logic [40:0] din,
                        output logic [40:0] dout);
        dout = '0;
        step(1'b1, 1'b0);
        if (is_ir)
            step(1'b1, 1'b0);
        step(1'b0, 1'b0);
        step(1'b0, 1'b0);  // capture
        for (int i = 0; i < len; i++) begin
            dout[i] = o_tdo;
            step(i == len - 1, din[i]);
        end
        step(1'b1, 1'b0);
        step(1'b0, 1'b0);  // update
    endtask

    task automatic abort_run(input string what);
        u_check.report_error(what);
        u_check.print_counts();
        $display("STATUS: FAIL");
        $finish;
    endtask

    // request scan, then nop scans while the status reads busy
    task automatic dmi_access(input logic [1:0] op, input dmi_pkg::dmi_addr_t addr,
                              input dmi_pkg::dmi_data_t data, output logic [40:0] cap);
        int polls;
        scan(1'b0, dmi_pkg::DBUS_LEN, {addr, data, op}, cap);
        polls = 0;
        do begin
            scan(1'b0, dmi_pkg::DBUS_LEN, '0, cap);
            polls++;
        end while (cap[1:0] == 2'h3 && polls < POLL_MAX);
        if (cap[1:0] == 2'h3)
            abort_run("DBUS status stayed busy");
    endtask

    task automatic wait_host_idle();
        int n;
        n = 0;
        while (o_host_busy && n < WAIT_MAX) begin
            tick();
            n++;
        end
        if (o_host_busy)
            abort_run("host port busy did not clear");
    endtask

    task automatic host_access(input logic wr, input dmi_pkg::dmi_addr_t addr,
                               input dmi_pkg::dmi_data_t data, output dmi_pkg::dmi_data_t rd);
        wait_host_idle();
        i_host_req   = 1'b1;
        i_host_write = wr;
        i_host_addr  = addr;
        i_host_wdata = data;
        tick();
        i_host_req = 1'b0;
        wait_host_idle();
        rd = o_host_rdata;
    endtask

    // sixteen mapped words, anything else sets the sticky error
    function automatic dmi_pkg::dmi_data_t model_access(input logic wr,
            input dmi_pkg::dmi_addr_t addr, input dmi_pkg::dmi_data_t data);
        if (addr >= 7'd16) begin
            model_err = 1'b1;
            return '0;
        end
        if (wr)
            model[addr[3:0]] = data;
        return model[addr[3:0]];
    endfunction

    function automatic logic [1:0] exp_stat();
        return model_err ? 2'h2 : 2'h0;  // failed or success
    endfunction

    function automatic logic [31:0] ctrl_word();
        return {20'h0, exp_stat(), 6'd7, 4'd1};  // dmistat, abits, version
    endfunction

    task automatic host_readback(input string name);
        dmi_pkg::dmi_data_t rd;
        for (int i = 0; i < 16; i++) begin
            host_access(1'b0, 7'(i), '0, rd);
            u_check.check(name, model[i], rd);
        end
    endtask

    initial begin
        logic [40:0]        cap;
        logic [40:0]        din;
        dmi_pkg::dmi_addr_t a;
        dmi_pkg::dmi_addr_t ha;
        dmi_pkg::dmi_data_t d;
        dmi_pkg::dmi_data_t hd;
        dmi_pkg::dmi_data_t hrd;
        dmi_pkg::dmi_data_t exp_tap;
        dmi_pkg::dmi_data_t exp_host;
        logic               tap_wr;
        logic               host_wr;
        int                 off;

        void'($urandom(32'h1c9b_56d8));
        i_trst       = 1'b1;
        i_tms        = 1'b1;
        i_tdi        = 1'b0;
        i_host_req   = 1'b0;
        i_host_write = 1'b0;
        i_host_addr  = '0;
        i_host_wdata = '0;
        model_err    = 1'b0;
        bypass_bit   = 1'b0;
        foreach (model[i])
            model[i] = '0;
        repeat (8) @(posedge i_tck);
        #2;
        i_trst = 1'b0;

        tap_reset();
        scan(1'b0, 32, '0, cap);  // IDCODE is selected out of reset
        u_check.check("idcode", 32'h10e31913, cap);
        scan(1'b1, 5, 41'h1f, cap);
        u_check.check("ir_capture", 2'b01, cap[1:0]);

        // BYPASS delays the stream by one bit
        repeat (2) begin
            din = 41'($urandom);
            scan(1'b0, 16, din, cap);
            u_check.check("bypass_stream", {din[14:0], bypass_bit}, cap[15:0]);
            bypass_bit = din[15];
        end

        scan(1'b1, 5, 41'h10, cap);
        scan(1'b0, 32, '0, cap);
        u_check.check("dtmcontrol", ctrl_word(), cap);
        scan(1'b1, 5, 41'h11, cap);
        dmi_access(2'b01, 7'h40, '0, cap);
        d = model_access(1'b0, 7'h40, '0);
        u_check.check("unmapped_read", {7'h40, d, exp_stat()}, cap);
        scan(1'b1, 5, 41'h10, cap);
        scan(1'b0, 32, '0, cap);
        u_check.check("dtmcontrol_failed", ctrl_word(), cap);
        scan(1'b0, 32, 41'h1_0000, cap);  // dmireset
        model_err = 1'b0;
        scan(1'b0, 32, '0, cap);
        u_check.check("dtmcontrol_cleared", ctrl_word(), cap);

        scan(1'b1, 5, 41'h11, cap);
        repeat (12) begin
            a       = 7'($urandom % 16);
            d       = $urandom;
            tap_wr  = 1'($urandom);
            exp_tap = model_access(tap_wr, a, d);
            dmi_access(tap_wr ? 2'b10 : 2'b01, a, d, cap);
            if (tap_wr)
                u_check.check("jtag_write_status", {a, exp_stat()}, {cap[40:34], cap[1:0]});
            else
                u_check.check("jtag_read", {a, exp_tap, exp_stat()}, cap);
        end

        // host strobes land around the TAP update, same cycle every third round
        for (int n = 0; n < 16; n++) begin
            a       = 7'($urandom % 4);
            ha      = 7'($urandom % 4);
            d       = $urandom;
            hd      = $urandom;
            tap_wr  = 1'($urandom);
            host_wr = 1'($urandom);
            off     = (n % 3 == 0) ? UPD_CYCLE : UPD_CYCLE - 2 + int'($urandom % 5);
            if (off < UPD_CYCLE) begin
                exp_host = model_access(host_wr, ha, hd);
                exp_tap  = model_access(tap_wr, a, d);
            end else begin
                exp_tap  = model_access(tap_wr, a, d);  // TAP wins a tie
                exp_host = model_access(host_wr, ha, hd);
            end
            fork
                dmi_access(tap_wr ? 2'b10 : 2'b01, a, d, cap);
                begin
                    repeat (off) tick();
                    host_access(host_wr, ha, hd, hrd);
                end
            join
            if (!tap_wr)
                u_check.check("mixed_jtag_read", {a, exp_tap, exp_stat()}, cap);
            if (!host_wr)
                u_check.check("mixed_host_read", exp_host, hrd);
        end
        host_readback("host_readback");

        scan(1'b1, 5, 41'h10, cap);
        scan(1'b0, 32, 41'h2_0000, cap);  // dmihardreset
        foreach (model[i])
            model[i] = '0;
        model_err = 1'b0;
        scan(1'b1, 5, 41'h11, cap);
        repeat (4) begin
            a = 7'($urandom % 16);
            dmi_access(2'b01, a, '0, cap);
            u_check.check("jtag_after_hardreset", {a, model[a[3:0]], exp_stat()}, cap);
        end
        host_readback("host_after_hardreset");

        u_check.print_counts();
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== tb.f ====
src/jtag_pkg.sv
src/dmi_pkg.sv
src/dmi_if.sv
src/jtag_dtm.sv
src/dmi_arbiter.sv
src/dm_data_regs.sv
src/dbg_top.sv
bench/tb_checker.sv
bench/tb_top.sv

// ==== run.sh ====
#!/bin/sh
# build the debug transport testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --assert -Wno-fatal --top-module tb_top -f tb.f -Mdir obj_dir -o tb_sim
./obj_dir/tb_sim | tee sim.log
if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
exit 0
